//--- run.sh
#!/bin/sh
# build and run the mul/div unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module mulDivTb -Mdir obj_dir \
  > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "compile failed"
  exit 1
fi

./obj_dir/VmulDivTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- sim.f
+incdir+verif
source/isaPkg.sv
source/fuPkg.sv
source/mulDivDecode.sv
source/mulDivArith.sv
source/resultPipe.sv
source/mulDivUnit.sv
verif/mulDivProps.sv
verif/mulDivTb.sv

//--- source/fuPkg.sv
package fuPkg;

  // writeback flags, executed is the msb
  typedef struct packed {
    logic executed;   // op was handled by this unit
    logic exception;  // divide by zero
    logic destValid;  // result should be written to phyDest
  } exeFlags_t;

  // which word of the arithmetic goes back
  typedef enum logic [2:0] {
    selNone      = 3'd0,  // non-M op, zero data
    selProductLo = 3'd1,
    selProductHi = 3'd2,
    selQuotient  = 3'd3,
    selRemainder = 3'd4
  } resultSel_t;

  // packet issued to the unit
  typedef struct packed {
    logic              valid;
    isaPkg::instWord_t inst;
    logic [7:0]        seqNo;
    logic [6:0]        phyDest;
    logic              phyDestValid;
  } exePkt_t;

  // packet returned on writeback
  typedef struct packed {
    logic          valid;
    logic [7:0]    seqNo;
    logic [6:0]    phyDest;
    isaPkg::data_t destData;
    exeFlags_t     flags;
  } wbPkt_t;

  // full 128-bit product, or its two halves
  typedef union packed {
    logic [2*isaPkg::dataWidth-1:0] full;
    struct packed {
      isaPkg::data_t hi;  // mulh / mulhu
      isaPkg::data_t lo;  // mul
    } half;
  } product_u;

  // decode result handed to the arithmetic
  typedef struct packed {
    resultSel_t sel;
    logic       isSigned;   // operands taken as two's complement
    logic       divByZero;  // div/rem with zero divisor
    exeFlags_t  flags;
  } decodeCtl_t;

endpackage

//--- source/isaPkg.sv
package isaPkg;

  // integer register width, RV64
  localparam int dataWidth = 64;

  // one operand or result word
  typedef logic [dataWidth-1:0] data_t;

  // R-type view of a 32-bit instruction
  typedef struct packed {
    logic [6:0] funct7;  // 7'b0000001 selects M ext on OP
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;  // picks the mul/div flavour
    logic [4:0] rd;
    logic [6:0] opcode;
  } instWord_t;

  // major opcode for register-register ALU ops
  localparam logic [6:0] opOp      = 7'b0110011;

  // funct7 shared by every M-extension op
  localparam logic [6:0] fn7MulDiv = 7'b0000001;

  // multiply group
  localparam logic [2:0] fn3Mul    = 3'b000;  // low half
  localparam logic [2:0] fn3Mulh   = 3'b001;  // high half, signed x signed
  localparam logic [2:0] fn3Mulhu  = 3'b011;  // high half, unsigned x unsigned

  // divide group
  localparam logic [2:0] fn3Div    = 3'b100;
  localparam logic [2:0] fn3Divu   = 3'b101;
  localparam logic [2:0] fn3Rem    = 3'b110;
  localparam logic [2:0] fn3Remu   = 3'b111;

  // funct3 010 (mulhsu) has no entry, decodes as a non-M op

endpackage

//--- source/mulDivArith.sv
module mulDivArith (
  input  fuPkg::decodeCtl_t ctl_i,
  input  isaPkg::data_t     data1_i,   // multiplicand / dividend
  input  isaPkg::data_t     data2_i,   // multiplier / divisor
  output isaPkg::data_t     result_o
);

  import isaPkg::*;
  import fuPkg::*;

  localparam data_t mostNegative = {1'b1, {(dataWidth-1){1'b0}}};

  logic negA;                        // dividend / multiplicand negative
  logic negB;
  logic [2*dataWidth-1:0] opA;       // operands widened to product width
  logic [2*dataWidth-1:0] opB;
  product_u product;

  data_t absA;                       // magnitudes for the divider
  data_t absB;
  data_t safeDivisor;                // never zero, keeps the divider defined
  data_t magQuot;
  data_t magRem;
  logic  overflow;                   // most negative / -1
  data_t quotient;
  data_t remainder;

  // sign only counts for signed ops
  assign negA = ctl_i.isSigned & data1_i[dataWidth-1];
  assign negB = ctl_i.isSigned & data2_i[dataWidth-1];

  // sign or zero extend to 128 bits, then one multiplier covers both cases
  assign opA = {{dataWidth{negA}}, data1_i};
  assign opB = {{dataWidth{negB}}, data2_i};
  assign product.full = opA * opB;   // low 128 bits are the exact product

  // divide on magnitudes, fix the signs afterwards
  assign absA        = negA ? -data1_i : data1_i;
  assign absB        = negB ? -data2_i : data2_i;
  assign safeDivisor = (absB == '0) ? data_t'(1) : absB;
  assign magQuot     = absA / safeDivisor;
  assign magRem      = absA % safeDivisor;

  assign overflow = ctl_i.isSigned && (data1_i == mostNegative) && (data2_i == '1);

  always_comb
  begin
    if (ctl_i.divByZero)
    begin
      quotient  = '1;        // all ones per the ISA
      remainder = data1_i;   // dividend unchanged
    end
    else if (overflow)
    begin
      quotient  = data1_i;   // wraps back to the dividend
      remainder = '0;
    end
    else
    begin
      // quotient negative when signs differ
      quotient  = (negA ^ negB) ? -magQuot : magQuot;
      // remainder follows the dividend's sign
      remainder = negA ? -magRem : magRem;
    end
  end

  always_comb
  begin
    case (ctl_i.sel)
      selProductLo: result_o = product.half.lo;
      selProductHi: result_o = product.half.hi;
      selQuotient:  result_o = quotient;
      selRemainder: result_o = remainder;
      default:      result_o = '0;  // non-M op
    endcase
  end

endmodule

//--- source/mulDivDecode.sv
module mulDivDecode (
  input  isaPkg::instWord_t  inst_i,
  input  logic               phyDestValid_i,
  input  isaPkg::data_t      divisor_i,   // rs2 operand
  output fuPkg::decodeCtl_t  ctl_o
);

  import isaPkg::*;
  import fuPkg::*;

  logic isMulDiv;     // OP opcode with M funct7
  logic zeroDivisor;
  logic isDivide;     // quotient or remainder chosen

  assign isMulDiv    = (inst_i.opcode == opOp) && (inst_i.funct7 == fn7MulDiv);
  assign zeroDivisor = (divisor_i == '0);

  always_comb
  begin
    ctl_o     = '0;
    ctl_o.sel = selNone;  // default for anything not recognised
    isDivide  = 1'b0;

    if (isMulDiv)
    begin
      case (inst_i.funct3)
        fn3Mul:
        begin
          ctl_o.sel      = selProductLo;
          ctl_o.isSigned = 1'b1;  // low half identical either way
        end
        fn3Mulh:
        begin
          ctl_o.sel      = selProductHi;
          ctl_o.isSigned = 1'b1;
        end
        fn3Mulhu:
          ctl_o.sel = selProductHi;  // unsigned high half
        fn3Div:
        begin
          ctl_o.sel      = selQuotient;
          ctl_o.isSigned = 1'b1;
        end
        fn3Divu:
          ctl_o.sel = selQuotient;
        fn3Rem:
        begin
          ctl_o.sel      = selRemainder;
          ctl_o.isSigned = 1'b1;
        end
        fn3Remu:
          ctl_o.sel = selRemainder;
        default:
          ctl_o.sel = selNone;  // mulhsu not handled here
      endcase

      // every recognised op executes and may write back
      if (ctl_o.sel != selNone)
      begin
        ctl_o.flags.executed  = 1'b1;
        ctl_o.flags.destValid = phyDestValid_i;
      end

      isDivide = (ctl_o.sel == selQuotient) || (ctl_o.sel == selRemainder);
      if (isDivide)
      begin
        ctl_o.divByZero       = zeroDivisor;
        ctl_o.flags.exception = zeroDivisor;  // result still defined, see arith
      end
    end
  end

endmodule

//--- source/mulDivUnit.sv
module mulDivUnit #(
  parameter int DEPTH = 4               // issue to writeback latency
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           recoverFlag_i,  // flush everything in flight
  input  fuPkg::exePkt_t exePacket_i,
  input  isaPkg::data_t  data1_i,
  input  isaPkg::data_t  data2_i,
  output fuPkg::wbPkt_t  wbPacket_o
);

  import isaPkg::*;
  import fuPkg::*;

  decodeCtl_t ctl;
  data_t      result;
  wbPkt_t     wbNow;     // packet as it would look with zero latency

  mulDivDecode mulDivDecode_inst (
    .inst_i         (exePacket_i.inst),
    .phyDestValid_i (exePacket_i.phyDestValid),
    .divisor_i      (data2_i),
    .ctl_o          (ctl)
  );

  mulDivArith mulDivArith_inst (
    .ctl_i    (ctl),
    .data1_i  (data1_i),
    .data2_i  (data2_i),
    .result_o (result)
  );

  // carry only the tags the core needs back
  assign wbNow.valid    = exePacket_i.valid;
  assign wbNow.seqNo    = exePacket_i.seqNo;
  assign wbNow.phyDest  = exePacket_i.phyDest;
  assign wbNow.destData = result;
  assign wbNow.flags    = ctl.flags;

  resultPipe #(
    .DEPTH (DEPTH)
  ) resultPipe_inst (
    .clk           (clk),
    .reset         (reset),
    .recoverFlag_i (recoverFlag_i),
    .pkt_i         (wbNow),
    .pkt_o         (wbPacket_o)
  );

endmodule

//--- source/resultPipe.sv
module resultPipe #(
  parameter int DEPTH = 4           // register stages, at least 1
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          recoverFlag_i,
  input  fuPkg::wbPkt_t pkt_i,      // un-delayed writeback packet
  output fuPkg::wbPkt_t pkt_o
);

  import fuPkg::*;

  logic [DEPTH-1:0] validQ;         // per-stage valid, stage 0 nearest the input
  wbPkt_t           stageQ [DEPTH]; // payload shift register

  // valid chain, cleared on reset and on recovery
  always_ff @(posedge clk)
  begin
    if (reset || recoverFlag_i)
    begin
      validQ <= '0;   // recovery also drops the packet on the input
    end
    else
    begin
      validQ[0] <= pkt_i.valid;
      for (int i = 1; i < DEPTH; i++)
      begin
        validQ[i] <= validQ[i-1];
      end
    end
  end

  // payload just shifts, valid bit decides if it means anything
  always_ff @(posedge clk)
  begin
    stageQ[0] <= pkt_i;
    for (int i = 1; i < DEPTH; i++)
    begin
      stageQ[i] <= stageQ[i-1];
    end
  end

  always_comb
  begin
    pkt_o       = stageQ[DEPTH-1];
    pkt_o.valid = validQ[DEPTH-1];  // take valid from the reset chain
  end

endmodule

//--- verif/mulDivProps.sv
module mulDivProps #(
  parameter int DEPTH = 4
) (
  input logic          clk,
  input logic          reset,
  input logic          recoverFlag_i,
  input fuPkg::wbPkt_t wbPacket_i
);

  logic resetSeen = 1'b0;  // no checks before the first reset edge
  int   sinceReset;        // edges since reset dropped
  int   sinceRecover;      // edges since the last flush

  always @(posedge clk)
  begin
    resetSeen <= resetSeen | reset;
    if (reset)
    begin
      sinceReset   <= 0;
      sinceRecover <= DEPTH;  // idle
    end
    else
    begin
      if (sinceReset < DEPTH)
        sinceReset <= sinceReset + 1;
      if (recoverFlag_i)
        sinceRecover <= 0;
      else if (sinceRecover < DEPTH)
        sinceRecover <= sinceRecover + 1;
    end
  end

  // quiet through reset and while the pipe refills
  assert property (@(posedge clk)
    (resetSeen && (reset || sinceReset < DEPTH)) |-> !wbPacket_i.valid)
    else $error("valid output during reset or within DEPTH cycles after it");

  // flushed stages never show up
  assert property (@(posedge clk) disable iff (reset)
    (resetSeen && sinceRecover < DEPTH) |-> !wbPacket_i.valid)
    else $error("valid output within DEPTH cycles after recovery");

  assert property (@(posedge clk) disable iff (reset)
    (wbPacket_i.valid && wbPacket_i.flags.exception) |-> wbPacket_i.flags.executed)
    else $error("exception flag set without executed");

endmodule

bind mulDivUnit mulDivProps #(
  .DEPTH (DEPTH)
) mulDivProps_inst (
  .clk           (clk),
  .reset         (reset),
  .recoverFlag_i (recoverFlag_i),
  .wbPacket_i    (wbPacket_o)
);

//--- verif/mulDivTests.svh
// drive one packet 1 unit after the edge, model its writeback
task automatic issueOp(input logic [6:0] opcode, input logic [6:0] fn7, input logic [2:0] fn3,
                       input data_t a, input data_t b, input logic recover);
  exePkt_t   pkt;
  expEntry_t entry;
  @(posedge clk);
  #1;
  pkt.valid        = 1'b1;
  pkt.inst         = makeInst(opcode, fn7, fn3);
  pkt.seqNo        = nextSeq;
  pkt.phyDest      = 7'($urandom_range(127, 0));
  pkt.phyDestValid = 1'($urandom_range(1, 0));
  nextSeq          = nextSeq + 8'd1;
  exePacket        = pkt;
  data1            = a;
  data2            = b;
  recoverFlag      = recover;
  if (recover)
    flushInFlight();  // packet on the inputs is dropped too
  else
  begin
    entry.pkt = modelWb(pkt, a, b);
    entry.due = cycleCount + DEPTH;
    expQ.push_back(entry);
  end
endtask

task automatic issueMulDiv(input logic [2:0] fn3, input data_t a, input data_t b);
  issueOp(opOp, fn7MulDiv, fn3, a, b, 1'b0);
endtask

// keep only what leaves the pipe this cycle
task automatic flushInFlight();
  expEntry_t kept [$];
  foreach (expQ[i])
  begin
    if (expQ[i].due <= cycleCount)
      kept.push_back(expQ[i]);
  end
  expQ = kept;
endtask

task automatic drainPipe();
  @(posedge clk);
  #1;
  exePacket.valid = 1'b0;
  recoverFlag     = 1'b0;
  while (expQ.size() != 0)
    @(posedge clk);
  @(posedge clk);
endtask

task automatic finishTest(input string name, input int errBefore);
  $display("%s finished, %0d errors", name, errorCount - errBefore);
endtask

task automatic testMultiply();
  data_t edgeVals [4];
  data_t a;
  data_t b;
  int    errBefore;
  errBefore   = errorCount;
  edgeVals[0] = '0;
  edgeVals[1] = '1;
  edgeVals[2] = mostNeg;
  edgeVals[3] = 64'd7;
  foreach (edgeVals[i])
  begin
    foreach (edgeVals[j])
    begin
      issueMulDiv(fn3Mul, edgeVals[i], edgeVals[j]);
      issueMulDiv(fn3Mulh, edgeVals[i], edgeVals[j]);
      issueMulDiv(fn3Mulhu, edgeVals[i], edgeVals[j]);
    end
  end
  repeat (8)
  begin
    a = randWord();
    b = randWord();
    issueMulDiv(fn3Mul, a, b);
    issueMulDiv(fn3Mulh, a, b);
    issueMulDiv(fn3Mulhu, a, b);
  end
  drainPipe();
  finishTest("multiply", errBefore);
endtask

task automatic testDivide();
  data_t a;
  data_t b;
  int    errBefore;
  errBefore = errorCount;
  repeat (12)
  begin
    a = randWord();
    b = randWord() >> $urandom_range(60, 0);  // spread of divisor sizes
    if (b == '0)
      b = 64'd3;
    if ($urandom_range(1, 0) == 1)
      b = -b;
    issueMulDiv(fn3Div, a, b);
    issueMulDiv(fn3Divu, a, b);
    issueMulDiv(fn3Rem, a, b);
    issueMulDiv(fn3Remu, a, b);
  end
  drainPipe();
  finishTest("divide", errBefore);
endtask

task automatic testCorners();
  data_t dividends [3];
  int    errBefore;
  errBefore    = errorCount;
  dividends[0] = randWord();
  dividends[1] = mostNeg;
  dividends[2] = '0;
  foreach (dividends[i])
  begin
    issueMulDiv(fn3Div, dividends[i], '0);
    issueMulDiv(fn3Divu, dividends[i], '0);
    issueMulDiv(fn3Rem, dividends[i], '0);
    issueMulDiv(fn3Remu, dividends[i], '0);
  end
  issueMulDiv(fn3Div, mostNeg, '1);   // signed overflow
  issueMulDiv(fn3Rem, mostNeg, '1);
  issueMulDiv(fn3Divu, mostNeg, '1);  // plain unsigned, no overflow case
  issueMulDiv(fn3Remu, mostNeg, '1);
  drainPipe();
  finishTest("corners", errBefore);
endtask

task automatic testNonM();
  int errBefore;
  errBefore = errorCount;
  issueOp(opOp, 7'b0000000, 3'b000, randWord(), randWord(), 1'b0);     // add
  issueOp(opOp, fn7MulDiv, 3'b010, randWord(), randWord(), 1'b0);      // mulhsu
  issueOp(7'b0000011, fn7MulDiv, fn3Div, randWord(), '0, 1'b0);        // load opcode
  issueOp(opOp, 7'b0100000, fn3Mul, randWord(), randWord(), 1'b0);     // sub
  drainPipe();
  finishTest("non-M", errBefore);
endtask

task automatic testRecovery();
  int errBefore;
  errBefore = errorCount;
  repeat (6)
    issueMulDiv(fn3Mul, randWord(), randWord());
  issueOp(opOp, fn7MulDiv, fn3Div, randWord(), randWord(), 1'b1);  // flush pulse
  repeat (4)
    issueMulDiv(fn3Rem, randWord(), randWord() | 64'd1);
  drainPipe();
  finishTest("recovery", errBefore);
endtask

//--- verif/mulDivTb.sv
module mulDivTb;

  import isaPkg::*;
  import fuPkg::*;

  localparam int DEPTH = 4;
  localparam data_t mostNeg = {1'b1, {(dataWidth-1){1'b0}}};

  // per test cycle budgets: reset, mul, div, corners, non-M, recovery, slack
  localparam int watchdogCycles = 3 + 80 + 60 + 26 + 12 + 22 + 100;

  // expected packet and the cycle it must show up in
  typedef struct packed {
    wbPkt_t pkt;
    int     due;
  } expEntry_t;

  logic        clk;
  logic        reset;
  logic        recoverFlag;
  exePkt_t     exePacket;
  data_t       data1;
  data_t       data2;
  wbPkt_t      wbPacket;

  expEntry_t   expQ [$];      // in flight, oldest first
  expEntry_t   headEntry;
  int          cycleCount = 0;
  int          errorCount = 0;
  int          checkCount = 0;
  logic [7:0]  nextSeq;
  int unsigned seedValue;

  mulDivUnit #(
    .DEPTH (DEPTH)
  ) mulDivUnit_inst (
    .clk           (clk),
    .reset         (reset),
    .recoverFlag_i (recoverFlag),
    .exePacket_i   (exePacket),
    .data1_i       (data1),
    .data2_i       (data2),
    .wbPacket_o    (wbPacket)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
    cycleCount <= cycleCount + 1;

  function automatic data_t randWord();
    return {$urandom, $urandom};
  endfunction

  function automatic instWord_t makeInst(input logic [6:0] opcode, input logic [6:0] fn7,
                                         input logic [2:0] fn3);
    instWord_t inst;
    inst.opcode = opcode;
    inst.funct7 = fn7;
    inst.funct3 = fn3;
    inst.rd     = 5'($urandom_range(31, 0));  // register fields are don't care
    inst.rs1    = 5'($urandom_range(31, 0));
    inst.rs2    = 5'($urandom_range(31, 0));
    return inst;
  endfunction

  // expected writeback straight from the M-extension rules
  function automatic wbPkt_t modelWb(input exePkt_t pkt, input data_t a, input data_t b);
    wbPkt_t              want;
    logic signed [127:0] sa;
    logic signed [127:0] sb;
    logic signed [127:0] sProd;
    logic [127:0]        uProd;
    logic signed [63:0]  sDividend;
    logic signed [63:0]  sDivisor;
    logic                signedDiv;
    data_t               quot;
    data_t               rem;
    want         = '0;
    want.valid   = pkt.valid;
    want.seqNo   = pkt.seqNo;
    want.phyDest = pkt.phyDest;
    if (pkt.inst.opcode != opOp || pkt.inst.funct7 != fn7MulDiv || pkt.inst.funct3 == 3'b010)
      return want;  // not handled here, zero data and flags
    sa        = $signed(a);  // sign extended to 128
    sb        = $signed(b);
    sProd     = sa * sb;
    uProd     = {64'd0, a} * {64'd0, b};
    sDividend = $signed(a);
    sDivisor  = $signed(b);
    signedDiv = (pkt.inst.funct3 == fn3Div) || (pkt.inst.funct3 == fn3Rem);
    if (b == '0)
    begin
      quot = '1;
      rem  = a;
    end
    else if (signedDiv && a == mostNeg && b == '1)
    begin
      quot = a;   // overflow wraps to the dividend
      rem  = '0;
    end
    else if (signedDiv)
    begin
      quot = data_t'(sDividend / sDivisor);
      rem  = data_t'(sDividend % sDivisor);  // sign of the dividend
    end
    else
    begin
      quot = a / b;
      rem  = a % b;
    end
    want.flags.executed  = 1'b1;
    want.flags.destValid = pkt.phyDestValid;
    want.flags.exception = pkt.inst.funct3[2] && (b == '0);  // div group only
    case (pkt.inst.funct3)
      fn3Mul:   want.destData = sProd[63:0];
      fn3Mulh:  want.destData = sProd[127:64];
      fn3Mulhu: want.destData = uProd[127:64];
      fn3Div:   want.destData = quot;
      fn3Divu:  want.destData = quot;
      fn3Rem:   want.destData = rem;
      default:  want.destData = rem;  // remu
    endcase
    return want;
  endfunction

  task automatic checkData(input data_t got, input data_t want, input logic [7:0] seq);
    checkCount++;
    if (got !== want)
    begin
      errorCount++;
      $display("[FAIL] %0t: seq %0d data got %h expected %h", $time, seq, got, want);
    end
  endtask

  task automatic checkFlags(input exeFlags_t got, input exeFlags_t want, input logic [7:0] seq);
    checkCount++;
    if (got !== want)
    begin
      errorCount++;
      $display("[FAIL] %0t: seq %0d flags got %b expected %b", $time, seq, got, want);
    end
  endtask

  task automatic checkPkt(input wbPkt_t got, input wbPkt_t want);
    checkCount++;
    if (got.seqNo !== want.seqNo || got.phyDest !== want.phyDest)
    begin
      errorCount++;
      $display("[FAIL] %0t: tags got seq %0d dest %0d expected seq %0d dest %0d",
               $time, got.seqNo, got.phyDest, want.seqNo, want.phyDest);
    end
    checkData(got.destData, want.destData, want.seqNo);
    checkFlags(got.flags, want.flags, want.seqNo);
  endtask

  // output sampled mid cycle, well away from the edge
  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (expQ.size() != 0 && expQ[0].due < cycleCount)
      begin
        headEntry = expQ.pop_front();
        errorCount++;
        $display("missing packet: seq %0d was due in cycle %0d and never came out",
                 headEntry.pkt.seqNo, headEntry.due);
      end
      if (wbPacket.valid === 1'b1)
      begin
        if (expQ.size() == 0 || expQ[0].due != cycleCount)
        begin
          errorCount++;
          $display("unexpected packet: seq %0d came out in cycle %0d with none due",
                   wbPacket.seqNo, cycleCount);
        end
        else
        begin
          headEntry = expQ.pop_front();
          checkPkt(wbPacket, headEntry.pkt);
        end
      end
    end
  end

  `include "mulDivTests.svh"

  initial
  begin
    seedValue       = $urandom(32'h0c9c8719);
    reset           = 1'b1;
    recoverFlag     = 1'b0;
    exePacket       = '0;
    exePacket.valid = 1'b1;  // valid while reset is high, must never come out
    data1           = '0;
    data2           = '0;
    nextSeq         = '0;
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
    exePacket.valid = 1'b0;  // nothing issued until the first test
    testMultiply();
    testDivide();
    testCorners();
    testNonM();
    testRecovery();
    $display("%0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  initial
  begin
    #(watchdogCycles * 10);
    $display("timeout: tests still running after %0d cycles", watchdogCycles);
    $display("TB FAILED");
    $finish;
  end

endmodule
